// ==== sources.f ====
hdl/ex_pkg.sv
hdl/alu_logic_shift.sv
hdl/alu_arith.sv
hdl/mul_unit.sv
hdl/hilo_reg.sv
hdl/ex_result_reg.sv
hdl/ex_unit_top.sv
verification/tb_clock_gen.sv
verification/ex_unit_properties.sv
verification/tb_ex_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ex_unit
LOG       ?= sim.log
BUILD_DIR ?= build
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_ex_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the execute unit that runs a table of operations in order
// through the four-phase handshake and checks every response
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_ex_unit import ex_pkg::*; ();

    localparam int CLK_PERIOD_NS = 4;
    localparam int N_TESTS       = 40;
    localparam int WATCHDOG_NS   = N_TESTS * 20 * CLK_PERIOD_NS;
    localparam int SEED          = 32'h118c;

    typedef struct packed {
        ex_req_t    op;
        word_t      exp_wdata;
        logic       exp_wreg;
        logic [3:0] hold;   // extra cycles req stays high after ack
    } test_row_t;

    logic      clk;
    logic      rst;
    logic      req;
    ex_req_t   op;
    logic      ack;
    ex_rsp_t   rsp;
    test_row_t rows [N_TESTS];
    int        n_rows;
    int        err_count;
    int        pass_count;
    int        assert_fails;
    word_t     ra;
    word_t     rb;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(10)) u_clk (
        .clk_o (clk),
        .rst_o (rst)
    );

    ex_unit_top DUT (
        .clk_i (clk),
        .rst_i (rst),
        .req_i (req),
        .op_i  (op),
        .ack_o (ack),
        .rsp_o (rsp)
    );

    task automatic add_row(input alu_sel_e sel, input alu_op_e aluop, input word_t r1,
                           input word_t r2, input logic wr, input word_t exp_wdata,
                           input logic exp_wreg, input int hold);
        rows[n_rows] = '{op: '{alusel: sel, aluop: aluop, reg1: r1, reg2: r2,
                               wd: reg_addr_t'(n_rows + 1), wreg: wr},
                         exp_wdata: exp_wdata, exp_wreg: exp_wreg, hold: 4'(hold)};
        n_rows++;
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic run_test(input int idx);
        test_row_t row;
        ex_rsp_t   held;
        int        errs_before;
        row         = rows[idx];
        errs_before = err_count;
        @(posedge clk);
        req <= 1'b1;
        op  <= row.op;
        @(negedge clk);
        while (!ack) @(negedge clk);
        check_value($sformatf("test %0d wdata", idx), 64'(rsp.wdata), 64'(row.exp_wdata));
        check_value($sformatf("test %0d wreg", idx), 64'(rsp.wreg), 64'(row.exp_wreg));
        check_value($sformatf("test %0d wd", idx), 64'(rsp.wd), 64'(row.op.wd));
        held = rsp;
        repeat (row.hold) begin
            @(negedge clk);
            check_value($sformatf("test %0d ack held", idx), 64'(ack), 64'(1'b1));
            check_value($sformatf("test %0d rsp held", idx), 64'(rsp), 64'(held));
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);   // wait out phase 4
        if (err_count == errs_before)
            pass_count++;
        $display("test %0d %s: %s", idx, row.op.aluop.name(),
                 (err_count == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: handshake did not complete within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        req        = 1'b0;
        op         = '0;
        n_rows     = 0;
        err_count  = 0;
        pass_count = 0;
        void'($urandom(SEED));

        add_row(SEL_MOVE,  OP_MFHI,  32'h0,        32'h0,        1, 32'h0,        1, 0);
        add_row(SEL_MOVE,  OP_MFLO,  32'h0,        32'h0,        1, 32'h0,        1, 0);
        add_row(SEL_LOGIC, OP_OR,    32'h0f0f0000, 32'h00ff00ff, 1, 32'h0fff00ff, 1, 0);
        add_row(SEL_LOGIC, OP_AND,   32'hff00ff00, 32'h0ff00ff0, 1, 32'h0f000f00, 1, 0);
        add_row(SEL_LOGIC, OP_NOR,   32'h0000ffff, 32'h00ff0000, 1, 32'hff000000, 1, 0);
        add_row(SEL_LOGIC, OP_XOR,   32'haaaa5555, 32'hffff0000, 1, 32'h55555555, 1, 0);
        add_row(SEL_SHIFT, OP_SLL,   32'h4,        32'h000000f1, 1, 32'h00000f10, 1, 0);
        add_row(SEL_SHIFT, OP_SRL,   32'h24,       32'h80000000, 1, 32'h08000000, 1, 0);
        add_row(SEL_SHIFT, OP_SRA,   32'h8,        32'h80001200, 1, 32'hff800012, 1, 0);
        add_row(SEL_ARITH, OP_ADDU,  32'hffffffff, 32'h2,        1, 32'h1,        1, 0);
        add_row(SEL_ARITH, OP_SUBU,  32'h0,        32'h1,        1, 32'hffffffff, 1, 0);
        add_row(SEL_ARITH, OP_ADD,   32'h7fffffff, 32'h1,        1, 32'h80000000, 0, 0);
        add_row(SEL_ARITH, OP_ADDU,  32'h7fffffff, 32'h1,        1, 32'h80000000, 1, 0);
        add_row(SEL_ARITH, OP_SUB,   32'h80000000, 32'h1,        1, 32'h7fffffff, 0, 0);
        add_row(SEL_ARITH, OP_SUB,   32'd10,       32'd3,        1, 32'd7,        1, 0);
        // -1 minus the most negative word fits, 0 minus it does not
        add_row(SEL_ARITH, OP_SUB,   32'hffffffff, 32'h80000000, 1, 32'h7fffffff, 1, 0);
        add_row(SEL_ARITH, OP_SUB,   32'h0,        32'h80000000, 1, 32'h80000000, 0, 0);
        add_row(SEL_ARITH, OP_SLT,   32'hffffffff, 32'h1,        1, 32'h1,        1, 0);
        add_row(SEL_ARITH, OP_SLTU,  32'hffffffff, 32'h1,        1, 32'h0,        1, 0);
        add_row(SEL_ARITH, OP_CLZ,   32'h0,        32'h0,        1, 32'd32,       1, 0);
        add_row(SEL_ARITH, OP_CLO,   32'hf0000000, 32'h0,        1, 32'd4,        1, 0);
        add_row(SEL_ARITH, OP_CLZ,   32'h00010000, 32'h0,        1, 32'd15,       1, 0);
        add_row(SEL_MUL,   OP_MUL,   32'hfffffffd, 32'd5,        1, 32'hfffffff1, 1, 0);
        // -2 * 3 lands in hi/lo only
        add_row(SEL_NONE,  OP_MULT,  32'hfffffffe, 32'd3,        0, 32'h0,        0, 0);
        add_row(SEL_MOVE,  OP_MFHI,  32'h0,        32'h0,        1, 32'hffffffff, 1, 0);
        add_row(SEL_MOVE,  OP_MFLO,  32'h0,        32'h0,        1, 32'hfffffffa, 1, 0);
        add_row(SEL_NONE,  OP_MULTU, 32'hffffffff, 32'hffffffff, 0, 32'h0,        0, 0);
        add_row(SEL_MOVE,  OP_MFHI,  32'h0,        32'h0,        1, 32'hfffffffe, 1, 0);
        add_row(SEL_MOVE,  OP_MFLO,  32'h0,        32'h0,        1, 32'h1,        1, 0);
        add_row(SEL_NONE,  OP_MTHI,  32'h12345678, 32'h0,        0, 32'h0,        0, 0);
        add_row(SEL_MOVE,  OP_MFLO,  32'h0,        32'h0,        1, 32'h1,        1, 0);
        add_row(SEL_MOVE,  OP_MFHI,  32'h0,        32'h0,        1, 32'h12345678, 1, 0);
        add_row(SEL_NONE,  OP_MTLO,  32'habcd0000, 32'h0,        0, 32'h0,        0, 0);
        add_row(SEL_MOVE,  OP_MFHI,  32'h0,        32'h0,        1, 32'h12345678, 1, 0);
        add_row(SEL_MOVE,  OP_MFLO,  32'h0,        32'h0,        1, 32'habcd0000, 1, 0);
        // req held six extra cycles with a single hi/lo write
        add_row(SEL_NONE,  OP_MULTU, 32'h00010000, 32'h00030000, 0, 32'h0,      0, 6);
        add_row(SEL_MOVE,  OP_MFHI,  32'h0,        32'h0,        1, 32'h3,        1, 0);
        ra = $urandom();
        rb = $urandom();
        add_row(SEL_LOGIC, OP_AND,   ra,           rb,           1, ra & rb,      1, 0);
        ra = $urandom();
        rb = $urandom();
        add_row(SEL_LOGIC, OP_XOR,   ra,           rb,           1, ra ^ rb,      1, 0);
        ra = $urandom();
        rb = $urandom();
        add_row(SEL_ARITH, OP_ADDU,  ra,           rb,           1, ra + rb,      1, 0);

        @(negedge clk);
        while (rst) @(negedge clk);
        for (int i = 0; i < n_rows; i++)
            run_test(i);

        assert_fails = DUT.u_result.u_props.fail_count;
        $display("%0d tests, %0d passed, %0d check errors, %0d assertion failures",
                 n_rows, pass_count, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== verification/ex_unit_properties.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake assertions for the result stage
// bound into every ex_result_reg instance
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ex_unit_properties import ex_pkg::*; (
    input logic    clk_i,
    input logic    rst_i,
    input logic    req_i,
    input logic    ack_i,
    input logic    commit_i,
    input ex_rsp_t rsp_i
);

    int fail_count = 0;

    ack_rise_a: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            fail_count++;
            $error("ack rose without a request");
        end

    ack_fall_a: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(ack_i) |-> !$past(req_i))
        else begin
            fail_count++;
            $error("ack fell while req still high");
        end

    rsp_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (ack_i && $past(ack_i)) |-> $stable(rsp_i))
        else begin
            fail_count++;
            $error("rsp changed while ack high");
        end

    // one commit per transaction and ack follows it
    commit_pulse_a: assert property (@(posedge clk_i) disable iff (rst_i)
        commit_i |=> (!commit_i && ack_i))
        else begin
            fail_count++;
            $error("commit longer than one cycle");
        end

endmodule

bind ex_result_reg ex_unit_properties u_props (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .ack_i    (ack_o),
    .commit_i (commit_o),
    .rsp_i    (rsp_o)
);

// ==== verification/tb_clock_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and power-on reset
// reset is held for RESET_CYCLES rising edges
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial clk_o = 1'b0;
    always #(PERIOD_NS / 2) clk_o = ~clk_o;

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// ==== hdl/ex_unit_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute unit top for one operation per req/ack four-phase transaction
// combinational function units feed the registered result and hi/lo
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ex_unit_top import ex_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    req_i,
    input  ex_req_t op_i,
    output logic    ack_o,
    output ex_rsp_t rsp_o
);

    word_t  logic_w;
    word_t  shift_w;
    word_t  arith_w;
    word_t  move_w;
    dword_t prod_w;
    logic   ov_w;
    logic   commit_w;   // hi/lo write strobe

    alu_logic_shift u_logic_shift (
        .aluop_i (op_i.aluop),
        .reg1_i  (op_i.reg1),
        .reg2_i  (op_i.reg2),
        .logic_o (logic_w),
        .shift_o (shift_w)
    );

    alu_arith u_arith (
        .aluop_i (op_i.aluop),
        .reg1_i  (op_i.reg1),
        .reg2_i  (op_i.reg2),
        .arith_o (arith_w),
        .ov_o    (ov_w)
    );

    mul_unit u_mul (
        .aluop_i (op_i.aluop),
        .reg1_i  (op_i.reg1),
        .reg2_i  (op_i.reg2),
        .prod_o  (prod_w)
    );

    hilo_reg u_hilo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .commit_i (commit_w),
        .aluop_i  (op_i.aluop),
        .reg1_i   (op_i.reg1),
        .prod_i   (prod_w),
        .move_o   (move_w)
    );

    ex_result_reg u_result (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req_i),
        .op_i     (op_i),
        .logic_i  (logic_w),
        .shift_i  (shift_w),
        .arith_i  (arith_w),
        .move_i   (move_w),
        .prod_i   (prod_w),
        .ov_i     (ov_w),
        .commit_o (commit_w),
        .ack_o    (ack_o),
        .rsp_o    (rsp_o)
    );

endmodule

// ==== hdl/ex_result_reg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result mux, overflow write cancel and four-phase responder
// response is registered on accept and held until the next accept
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ex_result_reg import ex_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    req_i,
    input  ex_req_t op_i,
    input  word_t   logic_i,
    input  word_t   shift_i,
    input  word_t   arith_i,
    input  word_t   move_i,
    input  dword_t  prod_i,
    input  logic    ov_i,
    output logic    commit_o,
    output logic    ack_o,
    output ex_rsp_t rsp_o
);

    ex_rsp_t rsp_next;
    logic    accept;

    always_comb begin
        rsp_next.wd   = op_i.wd;
        rsp_next.wreg = op_i.wreg && !ov_i;   // overflow drops the write
        case (op_i.alusel)
            SEL_LOGIC: rsp_next.wdata = logic_i;
            SEL_SHIFT: rsp_next.wdata = shift_i;
            SEL_ARITH: rsp_next.wdata = arith_i;
            SEL_MOVE:  rsp_next.wdata = move_i;
            SEL_MUL:   rsp_next.wdata = prod_i[WORD_W-1:0];
            default:   rsp_next.wdata = '0;
        endcase
    end

    // new request seen while idle
    assign accept   = req_i && !ack_o;
    assign commit_o = accept;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
            rsp_o <= '0;
        end else if (accept) begin
            ack_o <= 1'b1;
            rsp_o <= rsp_next;
        end else if (!req_i) begin
            ack_o <= 1'b0;   // requester released so phase 4 closes
        end
    end

endmodule

// ==== hdl/hilo_reg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HI/LO register pair written once per transaction on commit_i
// move_o reads the stored values for mfhi/mflo
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hilo_reg import ex_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    commit_i,
    input  alu_op_e aluop_i,
    input  word_t   reg1_i,
    input  dword_t  prod_i,
    output word_t   move_o
);

    word_t hi_q;
    word_t lo_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (commit_i) begin
            case (aluop_i)
                OP_MULT, OP_MULTU: begin
                    hi_q <= prod_i[2*WORD_W-1:WORD_W];
                    lo_q <= prod_i[WORD_W-1:0];
                end
                OP_MTHI: hi_q <= reg1_i;
                OP_MTLO: lo_q <= reg1_i;
                default: ;
            endcase
        end
    end

    // values before this commit
    always_comb begin
        case (aluop_i)
            OP_MFHI: move_o = hi_q;
            OP_MFLO: move_o = lo_q;
            default: move_o = '0;
        endcase
    end

endmodule

// ==== hdl/mul_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32x32 -> 64 multiplier from a magnitude product and a sign fix
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mul_unit import ex_pkg::*; (
    input  alu_op_e aluop_i,
    input  word_t   reg1_i,
    input  word_t   reg2_i,
    output dword_t  prod_o
);

    logic   is_signed;
    word_t  mag1;
    word_t  mag2;
    dword_t mag_prod;
    logic   neg;

    assign is_signed = (aluop_i == OP_MUL) || (aluop_i == OP_MULT);

    assign mag1 = (is_signed && reg1_i[WORD_W-1]) ? (~reg1_i + 1'b1) : reg1_i;
    assign mag2 = (is_signed && reg2_i[WORD_W-1]) ? (~reg2_i + 1'b1) : reg2_i;

    assign mag_prod = dword_t'(mag1) * dword_t'(mag2);
    assign neg      = is_signed && (reg1_i[WORD_W-1] ^ reg2_i[WORD_W-1]);

    assign prod_o = neg ? (~mag_prod + 1'b1) : mag_prod;   // multu passes straight

endmodule

// ==== hdl/alu_arith.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// add/sub, set-less-than and leading zero/one count
// ov_o flags signed overflow of add and sub only
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alu_arith import ex_pkg::*; (
    input  alu_op_e aluop_i,
    input  word_t   reg1_i,
    input  word_t   reg2_i,
    output word_t   arith_o,
    output logic    ov_o
);

    logic  is_sub;
    logic  op2_neg;
    word_t reg2_mux;
    word_t sum;
    logic  ov_sum;
    logic  lt;

    function automatic word_t count_lead_zeros(input word_t w);
        word_t cnt;
        logic  found;
        cnt   = '0;
        found = 1'b0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (w[i])
                found = 1'b1;
            else if (!found)
                cnt = cnt + 1'b1;
        end
        return cnt;
    endfunction

    // sub and slt go through the adder as reg1 + (-reg2)
    assign is_sub   = (aluop_i == OP_SUB || aluop_i == OP_SUBU || aluop_i == OP_SLT);
    assign reg2_mux = is_sub ? (~reg2_i + 1'b1) : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // sign of the true second operand, -reg2 when subtracting
    assign op2_neg = is_sub ? !reg2_i[WORD_W-1] : reg2_i[WORD_W-1];

    assign ov_sum = (reg1_i[WORD_W-1] == op2_neg) && (sum[WORD_W-1] != reg1_i[WORD_W-1]);

    // signed less-than from the operand signs and the difference
    assign lt = (aluop_i == OP_SLT) ?
                ((reg1_i[WORD_W-1] && !reg2_i[WORD_W-1]) ||
                 ((reg1_i[WORD_W-1] == reg2_i[WORD_W-1]) && sum[WORD_W-1])) :
                (reg1_i < reg2_i);

    assign ov_o = (aluop_i == OP_ADD || aluop_i == OP_SUB) && ov_sum;

    always_comb begin
        case (aluop_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: arith_o = sum;
            OP_SLT, OP_SLTU:                  arith_o = {{(WORD_W-1){1'b0}}, lt};
            OP_CLZ:                           arith_o = count_lead_zeros(reg1_i);
            OP_CLO:                           arith_o = count_lead_zeros(~reg1_i);
            default:                          arith_o = '0;
        endcase
    end

endmodule

// ==== hdl/alu_logic_shift.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational bitwise logic and shifter
// shift amount comes from reg1 and the value shifted is reg2
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alu_logic_shift import ex_pkg::*; (
    input  alu_op_e aluop_i,
    input  word_t   reg1_i,
    input  word_t   reg2_i,
    output word_t   logic_o,
    output word_t   shift_o
);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = reg1_i[SHAMT_W-1:0];

    always_comb begin
        case (aluop_i)
            OP_OR:   logic_o = reg1_i | reg2_i;
            OP_AND:  logic_o = reg1_i & reg2_i;
            OP_NOR:  logic_o = ~(reg1_i | reg2_i);
            OP_XOR:  logic_o = reg1_i ^ reg2_i;
            default: logic_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            OP_SLL: begin
                shift_o = reg2_i << shamt;
            end
            OP_SRL: begin
                shift_o = reg2_i >> shamt;
            end
            OP_SRA: begin
                shift_o = word_t'($signed(reg2_i) >>> shamt);   // sign fill
            end
            default: begin
                shift_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/ex_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, opcodes and handshake payload types for the execute unit
// imported by every module of the unit and by the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ex_pkg;

    localparam int WORD_W     = 32;
    localparam int SHAMT_W    = 5;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [2*WORD_W-1:0]   dword_t;    // product or {hi, lo}
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_OR,
        OP_AND,
        OP_NOR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MUL,
        OP_MULT,
        OP_MULTU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

    // which unit drives wdata
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH,
        SEL_MOVE,
        SEL_MUL
    } alu_sel_e;

    typedef struct packed {
        alu_sel_e  alusel;
        alu_op_e   aluop;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
    } ex_req_t;

    typedef struct packed {
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
    } ex_rsp_t;

endpackage
